/* verilog/flit_buf_pkg.sv */
package flit_buf_pkg;

    localparam int PAYLOAD_W  = 128;
    localparam int FLOW_ID_W  = 5;
    localparam int QOS_W      = 2;
    localparam int QOS_LEVELS = 4;
    localparam int SEQ_W      = 5;  // enough for 32 cells

    typedef logic [PAYLOAD_W-1:0]   payload_t;
    typedef logic [FLOW_ID_W-1:0]   flow_id_t;
    typedef logic [FLOW_ID_W:0]     out_id_t;     // port bit on top
    typedef logic [QOS_W-1:0]       qos_t;        // 3 is highest
    typedef logic [QOS_LEVELS-1:0]  qos_onehot_t; // bit n means level n
    typedef logic [SEQ_W-1:0]       seq_t;

    // binary qos to one-hot vote
    function automatic qos_onehot_t qos_to_onehot(qos_t q);
        qos_onehot_t oh;
        oh = qos_onehot_t'(1) << q;
        return oh;
    endfunction

endpackage

/* verilog/flit_offer_if.sv */
`timescale 1ns/1ns

interface flit_offer_if import flit_buf_pkg::*; ();

    logic     offer_valid;
    flow_id_t offer_id;
    qos_t     offer_qos;
    payload_t offer_payload;
    logic     pop;           // one-cycle strobe, removes the offered flit

    modport port (
        output offer_valid,
        output offer_id,
        output offer_qos,
        output offer_payload,
        input  pop
    );

    modport arb (
        input  offer_valid,
        input  offer_id,
        input  offer_qos,
        input  offer_payload,
        output pop
    );

endinterface

/* verilog/payload_store.sv */
`timescale 1ns/1ns

module payload_store import flit_buf_pkg::*; #(
    parameter int CELL_COUNT = 16
) (
    input  logic                  clk,
    input  logic [CELL_COUNT-1:0] i_write_sel,
    input  payload_t              i_payload,
    input  logic [CELL_COUNT-1:0] i_read_sel,
    output payload_t              o_payload
);

    payload_t mem [CELL_COUNT];

    always_ff @(posedge clk) begin
        for (int c = 0; c < CELL_COUNT; c++) begin
            if (i_write_sel[c]) begin
                mem[c] <= i_payload;
            end
        end
    end

    // read select is one-hot, so a plain AND-OR is enough
    always_comb begin
        o_payload = '0;
        for (int c = 0; c < CELL_COUNT; c++) begin
            o_payload |= mem[c] & {PAYLOAD_W{i_read_sel[c]}};
        end
    end

endmodule

/* verilog/flow_cell.sv */
`timescale 1ns/1ns

module flow_cell import flit_buf_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_load,
    input  flow_id_t    i_load_id,
    input  qos_t        i_load_qos,
    input  seq_t        i_load_seq,
    input  logic        i_pop_en,
    input  flow_id_t    i_pop_id,
    input  logic        i_pop_self,
    output logic        o_valid,
    output flow_id_t    o_id,
    output qos_t        o_qos,
    output logic        o_eligible,
    output qos_onehot_t o_qos_vote
);

    logic     valid;
    flow_id_t id;
    qos_t     qos;
    seq_t     seq;        // earlier same-id flits still stored
    logic     older_left;

    // an older flit of our flow is leaving through another cell
    assign older_left = i_pop_en & valid & (i_pop_id == id) & (seq != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            seq   <= '0;
        end else if (i_load) begin
            valid <= 1'b1;
            seq   <= i_load_seq;
        end else if (i_pop_self) begin
            valid <= 1'b0;
        end else if (older_left) begin
            seq <= seq - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            id  <= i_load_id;
            qos <= i_load_qos;
        end
    end

    assign o_valid    = valid;
    assign o_id       = id;
    assign o_qos      = qos;
    assign o_eligible = valid & (seq == '0);

    // blocked cells stay out of the vote
    assign o_qos_vote = o_eligible ? qos_to_onehot(qos) : '0;

endmodule

/* verilog/ingress_port.sv */
`timescale 1ns/1ns

module ingress_port import flit_buf_pkg::*; #(
    parameter int CELL_COUNT = 16
) (
    input  logic         clk,
    input  logic         rst_n,
    input  payload_t     i_payload,
    input  flow_id_t     i_id,
    input  qos_t         i_qos,
    input  logic         i_valid,
    output logic         o_ready,
    flit_offer_if.port   offer
);

    localparam int OCC_W = $clog2(CELL_COUNT + 1);

    logic                  accept;
    logic [CELL_COUNT-1:0] cell_valid;
    logic [CELL_COUNT-1:0] cell_elig;
    flow_id_t              cell_id   [CELL_COUNT];
    qos_t                  cell_qos  [CELL_COUNT];
    qos_onehot_t           cell_vote [CELL_COUNT];

    logic [CELL_COUNT-1:0] free_sel;
    logic [CELL_COUNT-1:0] load_sel;
    logic [CELL_COUNT-1:0] same_id;
    logic [CELL_COUNT-1:0] cand;
    logic [CELL_COUNT-1:0] read_sel;
    logic [CELL_COUNT-1:0] pop_sel;
    seq_t                  load_seq;
    qos_onehot_t           vote_or;
    qos_onehot_t           top_qos;
    flow_id_t              sel_id;
    qos_t                  sel_qos;

    logic [OCC_W-1:0]      occ;
    logic [OCC_W-1:0]      occ_next;

    assign accept = i_valid & o_ready;

    // lowest free cell
    assign free_sel = ~cell_valid & (cell_valid + 1'b1);
    assign load_sel = free_sel & {CELL_COUNT{accept}};
    assign pop_sel  = read_sel & {CELL_COUNT{offer.pop}};

    always_comb begin
        load_seq = '0;
        vote_or  = '0;
        for (int c = 0; c < CELL_COUNT; c++) begin
            same_id[c] = cell_valid[c] & (cell_id[c] == i_id) & ~pop_sel[c];
            load_seq   = load_seq + seq_t'(same_id[c]);
            vote_or    = vote_or | cell_vote[c];
        end
    end

    // keep only the top qos level
    always_comb begin
        if (vote_or[3])      top_qos = 4'b1000;
        else if (vote_or[2]) top_qos = 4'b0100;
        else if (vote_or[1]) top_qos = 4'b0010;
        else                 top_qos = vote_or;
    end

    always_comb begin
        for (int c = 0; c < CELL_COUNT; c++) begin
            cand[c] = |(cell_vote[c] & top_qos);
        end
    end

    assign read_sel = cand & (~cand + 1'b1);  // lowest index wins a tie

    always_comb begin
        sel_id  = '0;
        sel_qos = '0;
        for (int c = 0; c < CELL_COUNT; c++) begin
            if (read_sel[c]) begin
                sel_id  = sel_id | cell_id[c];
                sel_qos = sel_qos | cell_qos[c];
            end
        end
    end

    assign offer.offer_valid = |cell_elig;
    assign offer.offer_id    = sel_id;
    assign offer.offer_qos   = sel_qos;

    for (genvar c = 0; c < CELL_COUNT; c++) begin : g_cell
        flow_cell u_cell (
            .clk        (clk),
            .rst_n      (rst_n),
            .i_load     (load_sel[c]),
            .i_load_id  (i_id),
            .i_load_qos (i_qos),
            .i_load_seq (load_seq),
            .i_pop_en   (offer.pop),
            .i_pop_id   (sel_id),
            .i_pop_self (pop_sel[c]),
            .o_valid    (cell_valid[c]),
            .o_id       (cell_id[c]),
            .o_qos      (cell_qos[c]),
            .o_eligible (cell_elig[c]),
            .o_qos_vote (cell_vote[c])
        );
    end

    payload_store #(
        .CELL_COUNT (CELL_COUNT)
    ) u_store (
        .clk         (clk),
        .i_write_sel (load_sel),
        .i_payload   (i_payload),
        .i_read_sel  (read_sel),
        .o_payload   (offer.offer_payload)
    );

    assign occ_next = occ + OCC_W'(accept) - OCC_W'(offer.pop);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ     <= '0;
            o_ready <= 1'b1;
        end else begin
            occ     <= occ_next;
            o_ready <= occ_next < OCC_W'(CELL_COUNT);  // room after this edge
        end
    end

endmodule

/* verilog/port_arbiter.sv */
`timescale 1ns/1ns

module port_arbiter import flit_buf_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_ready,
    flit_offer_if.arb  offer_a,
    flit_offer_if.arb  offer_b,
    output logic       o_valid,
    output payload_t   o_payload,
    output out_id_t    o_id,
    output qos_t       o_qos
);

    logic     last_b;     // port served last, 1 means B
    logic     can_load;
    logic     any_offer;
    logic     load;
    logic     pick_b;
    flow_id_t win_id;

    assign can_load  = ~o_valid | i_ready;  // empty or leaving now
    assign any_offer = offer_a.offer_valid | offer_b.offer_valid;
    assign load      = can_load & any_offer;

    always_comb begin
        if (!offer_a.offer_valid) begin
            pick_b = offer_b.offer_valid;
        end else if (!offer_b.offer_valid) begin
            pick_b = 1'b0;
        end else if (offer_a.offer_qos != offer_b.offer_qos) begin
            pick_b = offer_b.offer_qos > offer_a.offer_qos;
        end else begin
            pick_b = ~last_b;  // equal qos, take turns
        end
    end

    assign offer_a.pop = load & ~pick_b;
    assign offer_b.pop = load & pick_b;
    assign win_id      = pick_b ? offer_b.offer_id : offer_a.offer_id;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
            last_b  <= 1'b1;   // so A goes first
        end else begin
            if (can_load) begin
                o_valid <= any_offer;
            end
            if (load) begin
                last_b <= pick_b;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            o_payload <= pick_b ? offer_b.offer_payload : offer_a.offer_payload;
            o_qos     <= pick_b ? offer_b.offer_qos : offer_a.offer_qos;
            o_id      <= {pick_b, win_id};
        end
    end

endmodule

/* verilog/dual_flit_buffer.sv */
`timescale 1ns/1ns

module dual_flit_buffer import flit_buf_pkg::*; #(
    parameter int CELL_COUNT = 16
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t i_payload_a,
    input  flow_id_t i_id_a,
    input  qos_t     i_qos_a,
    input  logic     i_valid_a,
    output logic     o_ready_a,
    input  payload_t i_payload_b,
    input  flow_id_t i_id_b,
    input  qos_t     i_qos_b,
    input  logic     i_valid_b,
    output logic     o_ready_b,
    output logic     o_valid_c,
    output payload_t o_payload_c,
    output out_id_t  o_id_c,
    output qos_t     o_qos_c,
    input  logic     i_ready_c
);

    flit_offer_if offer_a_if ();
    flit_offer_if offer_b_if ();

    ingress_port #(
        .CELL_COUNT (CELL_COUNT)
    ) u_port_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_payload (i_payload_a),
        .i_id      (i_id_a),
        .i_qos     (i_qos_a),
        .i_valid   (i_valid_a),
        .o_ready   (o_ready_a),
        .offer     (offer_a_if.port)
    );

    ingress_port #(
        .CELL_COUNT (CELL_COUNT)
    ) u_port_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_payload (i_payload_b),
        .i_id      (i_id_b),
        .i_qos     (i_qos_b),
        .i_valid   (i_valid_b),
        .o_ready   (o_ready_b),
        .offer     (offer_b_if.port)
    );

    port_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_ready   (i_ready_c),
        .offer_a   (offer_a_if.arb),
        .offer_b   (offer_b_if.arb),
        .o_valid   (o_valid_c),
        .o_payload (o_payload_c),
        .o_id      (o_id_c),
        .o_qos     (o_qos_c)
    );

endmodule

/* sim/dual_flit_buffer_assert.sv */
`timescale 1ns/1ns

module dual_flit_buffer_assert import flit_buf_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     o_valid_c,
    input logic     i_ready_c,
    input payload_t o_payload_c,
    input out_id_t  o_id_c,
    input qos_t     o_qos_c
);

    // held output must not move
    property held_output_stable;
        @(posedge clk) disable iff (!rst_n)
        (o_valid_c && !i_ready_c) |=>
            (o_valid_c && $stable(o_payload_c) && $stable(o_id_c) && $stable(o_qos_c));
    endproperty

    property idle_after_reset;
        @(posedge clk) $rose(rst_n) |=> !o_valid_c;
    endproperty

    a_held_stable: assert property (held_output_stable)
        else $error("output changed while held");

    a_reset_idle: assert property (idle_after_reset)
        else $error("o_valid_c high right after reset");

endmodule

bind dual_flit_buffer dual_flit_buffer_assert u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .o_valid_c   (o_valid_c),
    .i_ready_c   (i_ready_c),
    .o_payload_c (o_payload_c),
    .o_id_c      (o_id_c),
    .o_qos_c     (o_qos_c)
);

/* sim/tb_dual_flit_buffer.sv */
`timescale 1ns/1ns

module tb_dual_flit_buffer import flit_buf_pkg::*; ();

    localparam int CELL_COUNT = 16;

    typedef struct {
        int       test;
        bit       port;      // 1 means B
        flow_id_t id;
        qos_t     qos;
        bit       hold;      // keep i_ready_c low while loading
        payload_t payload;
    } entry_t;

    logic     clk;
    logic     rst_n;
    payload_t i_payload_a, i_payload_b;
    flow_id_t i_id_a, i_id_b;
    qos_t     i_qos_a, i_qos_b;
    logic     i_valid_a, i_valid_b;
    logic     o_ready_a, o_ready_b;
    logic     o_valid_c;
    payload_t o_payload_c;
    out_id_t  o_id_c;
    qos_t     o_qos_c;
    logic     i_ready_c;

    entry_t tab [$];
    int     exp_order [$];
    int     que_a [$];
    int     que_b [$];
    bit     model_last_b = 1'b1;  // arbiter starts with A
    integer seed = 32'hb6b6b0f9;

    dual_flit_buffer #(.CELL_COUNT(CELL_COUNT)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_payload(input string name, input payload_t exp, input payload_t act);
        if (exp !== act) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_id(input string name, input out_id_t exp, input out_id_t act);
        if (exp !== act) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_qos(input string name, input qos_t exp, input qos_t act);
        if (exp !== act) begin
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Error %s: expected %b, actual %b", name, exp, act);
            fail_now();
        end
    endtask

    task automatic add_entry(input int t, input bit p, input int id, input int q, input bit h);
        entry_t e;
        e.test    = t;
        e.port    = p;
        e.id      = flow_id_t'(id);
        e.qos     = qos_t'(q);
        e.hold    = h;
        e.payload = {$random(seed), $random(seed), $random(seed), $random(seed)};
        tab.push_back(e);
    endtask

    // position in a port queue of its offer, -1 when nothing is eligible
    function automatic int pick_offer(input bit p);
        int q [$];
        int best;
        bit blocked;
        if (p) q = que_b;
        else q = que_a;
        best = -1;
        for (int j = 0; j < q.size(); j++) begin
            blocked = 1'b0;
            for (int k = 0; k < j; k++) begin
                if (tab[q[k]].id == tab[q[j]].id) blocked = 1'b1;
            end
            if (!blocked && (best < 0 || tab[q[j]].qos > tab[q[best]].qos)) best = j;
        end
        return best;
    endfunction

    // first flit leaves alone, the rest drain by the arbitration rules
    task automatic build_order(input int idx [$]);
        int  ia;
        int  ib;
        bit  take_b;
        exp_order.delete();
        que_a.delete();
        que_b.delete();
        exp_order.push_back(idx[0]);
        model_last_b = tab[idx[0]].port;
        for (int j = 1; j < idx.size(); j++) begin
            if (tab[idx[j]].port) que_b.push_back(idx[j]);
            else que_a.push_back(idx[j]);
        end
        while (que_a.size() + que_b.size() > 0) begin
            ia = pick_offer(1'b0);
            ib = pick_offer(1'b1);
            if (ia < 0) take_b = 1'b1;
            else if (ib < 0) take_b = 1'b0;
            else if (tab[que_a[ia]].qos != tab[que_b[ib]].qos)
                take_b = tab[que_b[ib]].qos > tab[que_a[ia]].qos;
            else take_b = ~model_last_b;
            model_last_b = take_b;
            if (take_b) begin
                exp_order.push_back(que_b[ib]);
                que_b.delete(ib);
            end else begin
                exp_order.push_back(que_a[ia]);
                que_a.delete(ia);
            end
        end
    endtask

    task automatic send_flit(input int e);
        @(negedge clk);
        if (tab[e].port) begin
            i_payload_b = tab[e].payload;
            i_id_b      = tab[e].id;
            i_qos_b     = tab[e].qos;
            i_valid_b   = 1'b1;
        end else begin
            i_payload_a = tab[e].payload;
            i_id_a      = tab[e].id;
            i_qos_a     = tab[e].qos;
            i_valid_a   = 1'b1;
        end
        while (tab[e].port ? !o_ready_b : !o_ready_a) @(negedge clk);
        @(negedge clk);  // accepted on the edge in between
        i_valid_a = 1'b0;
        i_valid_b = 1'b0;
    endtask

    task automatic collect_flit(input string name, input int e);
        while (!o_valid_c) @(negedge clk);
        check_payload({name, " payload"}, tab[e].payload, o_payload_c);
        check_id({name, " id"}, {tab[e].port, tab[e].id}, o_id_c);
        check_qos({name, " qos"}, tab[e].qos, o_qos_c);
        @(negedge clk);
    endtask

    task automatic run_test(input int t, input string name);
        int idx [$];
        for (int j = 0; j < tab.size(); j++) begin
            if (tab[j].test == t) idx.push_back(j);
        end
        build_order(idx);
        if (tab[idx[0]].hold) begin
            i_ready_c = 1'b0;
            send_flit(idx[0]);
            while (!o_valid_c) @(negedge clk);
            for (int j = 1; j < idx.size(); j++) send_flit(idx[j]);
            if (t == 1) check_bit({name, " full ready"}, 1'b0, o_ready_a);
            check_payload({name, " held output"}, tab[idx[0]].payload, o_payload_c);
            i_ready_c = 1'b1;
            foreach (exp_order[k]) collect_flit(name, exp_order[k]);
        end else begin
            i_ready_c = 1'b1;
            foreach (exp_order[k]) begin
                send_flit(exp_order[k]);
                collect_flit(name, exp_order[k]);
            end
        end
        check_bit({name, " drained"}, 1'b0, o_valid_c);
    endtask

    initial begin
        rst_n = 1'b0;
        {i_payload_a, i_payload_b} = '0;
        {i_id_a, i_id_b, i_qos_a, i_qos_b} = '0;
        i_valid_a = 1'b0;
        i_valid_b = 1'b0;
        i_ready_c = 1'b1;

        add_entry(0, 0, 3, 2, 0);
        add_entry(0, 1, 7, 1, 0);
        for (int k = 0; k <= CELL_COUNT; k++) add_entry(1, 0, k, (k * 3) % 4, 1);
        add_entry(2, 0, 1, 0, 1);
        add_entry(2, 0, 5, 0, 1);
        add_entry(2, 0, 9, 1, 1);
        add_entry(2, 0, 5, 1, 1);
        add_entry(2, 0, 5, 3, 1);
        add_entry(2, 0, 2, 2, 1);
        add_entry(3, 0, 1, 1, 1);
        add_entry(3, 0, 4, 2, 1);
        add_entry(3, 1, 6, 2, 1);
        add_entry(3, 0, 8, 2, 1);
        add_entry(3, 1, 10, 1, 1);
        add_entry(3, 1, 11, 3, 1);
        add_entry(3, 0, 12, 0, 1);

        fork
            begin
                repeat (tab.size() * 40 + 200) @(posedge clk);
                $display("Timeout: the DUT stopped delivering flits");
                fail_now();
            end
        join_none

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("reset valid", 1'b0, o_valid_c);
        check_bit("reset ready a", 1'b1, o_ready_a);
        check_bit("reset ready b", 1'b1, o_ready_b);

        run_test(0, "pass_through");
        run_test(1, "fill");
        run_test(2, "same_id");
        run_test(3, "arbitration");

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* list.f */
verilog/flit_buf_pkg.sv
verilog/flit_offer_if.sv
verilog/payload_store.sv
verilog/flow_cell.sv
verilog/ingress_port.sv
verilog/port_arbiter.sv
verilog/dual_flit_buffer.sv
sim/dual_flit_buffer_assert.sv
sim/tb_dual_flit_buffer.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dual_flit_buffer
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
